/* usbRxFront.f */
source/usbRxFrontPkg.sv
source/usbPinFrontend.sv
source/eopResetDetect.sv
source/nrziBitDecoder.sv
source/rxByteAssembler.sv
source/usbRxFrontTop.sv
tests/usbRxFrontChk.sv
tests/usbRxFrontMon.sv
tests/usbRxFrontTb.sv

/* tests/usbRxFrontTb.sv */
`timescale 1ns/1ps

module usbRxFrontTb;
    import usbRxFrontPkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_RANDOM      = 20;
    localparam int NUM_PACKETS     = NUM_RANDOM + 4;   // Plus stuffing pair, cut and post-burst
    localparam int MAX_PKT_CLKS    = 320;              // 65 stuffed bits, EOP, gap and drain
    localparam int RESET_TEST_CLKS = 400;
    localparam int BURST_CLKS      = 40;
    localparam int DRAIN_LIMIT     = 64;
    localparam int EOP_CLKS        = 2 * SAMPLES_PER_BIT;
    localparam int RESET_SE0_CLKS  = 150;
    localparam int WATCHDOG_CLKS   = NUM_PACKETS * MAX_PKT_CLKS + RESET_TEST_CLKS
                                   + BURST_CLKS + 4 + 500;

    logic        clk48;
    logic        rst;
    logic        pinP;
    logic        pinN;
    logic        txEn;
    logic        txP;
    logic        txN;
    logic        ackUsbRst;
    logic        pinPOut;
    logic        pinNOut;
    logic        pinOe;
    logic        usbReset;
    rxByte_t     rxByte;
    pktEnd_t     pktEnd;
    logic [31:0] rngState;
    logic [31:0] r;
    byte_t       pktData[$];
    logic        txBits[$];
    int          len;
    int          cut;
    int          asserts;

    usbRxFrontTop DUT (
        .clk48_i     (clk48),
        .rst_i       (rst),
        .pinP_i      (pinP),
        .pinN_i      (pinN),
        .pinP_o      (pinPOut),
        .pinN_o      (pinNOut),
        .pinOe_o     (pinOe),
        .dataOutEn_i (txEn),
        .dataOutP_i  (txP),
        .dataOutN_i  (txN),
        .usbReset_o  (usbReset),
        .ackUsbRst_i (ackUsbRst),
        .rxByte_o    (rxByte),
        .pktEnd_o    (pktEnd)
    );

    usbRxFrontMon mon (
        .clk48_i    (clk48),
        .rst_i      (rst),
        .txEn_i     (txEn),
        .txP_i      (txP),
        .txN_i      (txN),
        .pinP_i     (pinPOut),
        .pinN_i     (pinNOut),
        .pinOe_i    (pinOe),
        .usbReset_i (usbReset),
        .rxByte_i   (rxByte),
        .pktEnd_i   (pktEnd)
    );

    initial begin
        clk48 = 1'b0;
        forever #(CLK_PERIOD / 2) clk48 = ~clk48;
    end

    function automatic logic [31:0] randWord();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic holdLine(input logic p, input logic n, input int clocks);
        repeat (clocks) begin
            @(posedge clk48);
            pinP <= p;
            pinN <= n;
        end
    endtask

    // Bit 2 and 6 cleared so no run of ones exceeds three
    task automatic fillRandom(input int count);
        pktData.delete();
        repeat (count) begin
            r = randWord();
            pktData.push_back(r[7:0] & 8'hBB);
        end
    endtask

    task automatic queueBytes(input int count);
        for (int k = 0; k < count; k++) begin
            mon.queueByte(pktData[k]);
        end
    endtask

    // SYNC and data LSB first, optional stuffing, NRZI from J, then SE0 and J
    task automatic sendPacket(input int cutBits, input logic stuffOn, input int se0Clocks);
        byte_t b;
        logic  level;
        int    ones;
        txBits.delete();
        for (int i = 0; i < 8; i++) begin
            txBits.push_back(i == 7);
        end
        for (int k = 0; k < pktData.size(); k++) begin
            b = pktData[k];
            for (int i = 0; i < 8; i++) begin
                txBits.push_back(b[i]);
            end
        end
        repeat (cutBits) void'(txBits.pop_back());
        level = 1'b1;
        ones = 0;
        for (int k = 0; k < txBits.size(); k++) begin
            if (!txBits[k]) begin
                level = ~level;    // Zero toggles the line
            end
            holdLine(level, ~level, SAMPLES_PER_BIT);
            ones = txBits[k] ? ones + 1 : 0;
            if (stuffOn && ones == STUFF_LIMIT) begin
                level = ~level;
                holdLine(level, ~level, SAMPLES_PER_BIT);
                ones = 0;
            end
        end
        holdLine(1'b0, 1'b0, se0Clocks);
        holdLine(1'b1, 1'b0, 3 * SAMPLES_PER_BIT);   // J, then idle gap
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while (mon.pending() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk48);
            n++;
        end
        repeat (4) @(posedge clk48);
    endtask

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk48);
        $display("Timeout: the run did not finish within %0d clocks", WATCHDOG_CLKS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst = 1'b1;
        pinP = 1'b1;
        pinN = 1'b0;
        txEn = 1'b0;
        txP = 1'b0;
        txN = 1'b0;
        ackUsbRst = 1'b0;
        rngState = 32'h8a77;
        repeat (4) @(posedge clk48);
        rst <= 1'b0;
        repeat (4) @(posedge clk48);

        for (int p = 0; p < NUM_RANDOM; p++) begin
            r = randWord();
            len = 1 + int'(r % 6);
            fillRandom(len);
            queueBytes(len);
            mon.queueEnd(1'b0);
            sendPacket(0, 1'b1, EOP_CLKS);
            waitDrain();
        end
        mon.finishTest("random packets");

        pktData = '{8'hFF, 8'h3F, 8'hFF};
        queueBytes(3);
        mon.queueEnd(1'b0);
        sendPacket(0, 1'b1, EOP_CLKS);
        waitDrain();
        pktData = '{8'hFF};      // Seven ones in a row with stuffing off
        mon.queueEnd(1'b1);
        sendPacket(0, 1'b0, EOP_CLKS);
        waitDrain();
        mon.finishTest("bit stuffing");

        r = randWord();
        len = 2 + int'(r % 5);
        r = randWord();
        cut = 1 + int'(r % 7);
        fillRandom(len);
        queueBytes(len - 1);     // Partial last byte is never strobed
        mon.queueEnd(1'b1);
        sendPacket(cut, 1'b1, EOP_CLKS);
        waitDrain();
        mon.finishTest("truncated packet");

        // Reset SE0 right after a packet body, the assembler is still in DATA
        fillRandom(1);
        queueBytes(1);
        mon.queueResetRise();
        sendPacket(0, 1'b1, RESET_SE0_CLKS);
        waitDrain();
        mon.queueEnd(1'b0);      // A normal EOP still closes the open packet
        holdLine(1'b0, 1'b0, EOP_CLKS);
        holdLine(1'b1, 1'b0, 3 * SAMPLES_PER_BIT);
        waitDrain();
        repeat (20) @(posedge clk48);
        mon.queueResetFall();
        @(posedge clk48);
        ackUsbRst <= 1'b1;
        @(posedge clk48);
        ackUsbRst <= 1'b0;
        waitDrain();
        mon.finishTest("bus reset");

        repeat (BURST_CLKS) begin
            @(posedge clk48);
            r = randWord();
            txEn <= 1'b1;
            txP  <= r[0];
            txN  <= r[1];
            pinP <= r[2];
            pinN <= r[3];
        end
        @(posedge clk48);
        txEn <= 1'b0;
        txP  <= 1'b0;
        txN  <= 1'b0;
        pinP <= 1'b1;
        pinN <= 1'b0;
        repeat (BLANK_TAIL) @(posedge clk48);
        mon.finishTest("transmit burst");

        fillRandom(3);
        queueBytes(3);
        mon.queueEnd(1'b0);
        sendPacket(0, 1'b1, EOP_CLKS);
        waitDrain();
        mon.finishTest("packet after burst");

        asserts = DUT.byteAssembler.chk.failCnt;
        $display("Summary: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
            mon.testNum, mon.testsFailed, mon.errCount, asserts);
        if (mon.errCount == 0 && asserts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tests/usbRxFrontMon.sv */
`timescale 1ns/1ps

module usbRxFrontMon
    import usbRxFrontPkg::*;
(
    input logic    clk48_i,
    input logic    rst_i,
    input logic    txEn_i,
    input logic    txP_i,
    input logic    txN_i,
    input logic    pinP_i,
    input logic    pinN_i,
    input logic    pinOe_i,
    input logic    usbReset_i,
    input rxByte_t rxByte_i,
    input pktEnd_t pktEnd_i
);

    // Event codes in the expected queue, kind * 256 + value
    localparam int EV_BYTE      = 0;
    localparam int EV_END       = 1;
    localparam int EV_RST_RISE  = 2;
    localparam int EV_RST_FALL  = 3;

    int   expQ[$];
    int   errCount    = 0;
    int   testErrs    = 0;
    int   testNum     = 0;
    int   testsFailed = 0;
    logic prevReset   = 1'b0;

    function automatic string kindName(input int kind);
        case (kind)
            EV_BYTE:     return "byte";
            EV_END:      return "packet end";
            EV_RST_RISE: return "bus reset rise";
            default:     return "bus reset fall";
        endcase
    endfunction

    function automatic int pending();
        return expQ.size();
    endfunction

    task automatic queueByte(input byte_t data);
        expQ.push_back(EV_BYTE * 256 + int'(data));
    endtask

    task automatic queueEnd(input logic err);
        expQ.push_back(EV_END * 256 + int'(err));
    endtask

    task automatic queueResetRise();
        expQ.push_back(EV_RST_RISE * 256);
    endtask

    task automatic queueResetFall();
        expQ.push_back(EV_RST_FALL * 256);
    endtask

    task automatic flagMismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errCount++;
        testErrs++;
    endtask

    task automatic checkEvent(input int kind, input int value);
        int want;
        if (expQ.size() == 0) begin
            flagMismatch($sformatf("unexpected %s, value 0x%02h", kindName(kind), value));
        end else begin
            want = expQ.pop_front();
            if (want != kind * 256 + value) begin
                flagMismatch($sformatf("expected %s 0x%02h, got %s 0x%02h",
                    kindName(want / 256), want % 256, kindName(kind), value));
            end
        end
    endtask

    // Outputs are stable half a clock after the edge
    always @(negedge clk48_i) begin
        if (pinOe_i !== txEn_i || pinP_i !== (txEn_i ? txP_i : 1'b1)
                || pinN_i !== (txEn_i ? txN_i : 1'b0)) begin
            flagMismatch($sformatf("pins P/N/OE %b%b%b do not follow transmit inputs %b%b%b",
                pinP_i, pinN_i, pinOe_i, txP_i, txN_i, txEn_i));
        end
        if (rst_i) begin
            prevReset = 1'b0;
        end else begin
            if (rxByte_i.valid) begin
                checkEvent(EV_BYTE, int'(rxByte_i.data));
            end
            if (pktEnd_i.valid) begin
                checkEvent(EV_END, int'(pktEnd_i.error));
            end
            if (usbReset_i && !prevReset) begin
                checkEvent(EV_RST_RISE, 0);
            end
            if (!usbReset_i && prevReset) begin
                checkEvent(EV_RST_FALL, 0);
            end
            prevReset = usbReset_i;
        end
    end

    task automatic finishTest(input string name);
        testNum++;
        if (expQ.size() != 0) begin
            $display("Test %0d %s: %0d expected outputs never appeared",
                testNum, name, expQ.size());
            errCount++;
            testErrs++;
            expQ.delete();
        end
        if (testErrs == 0) begin
            $display("Test %0d %s: passed", testNum, name);
        end else begin
            $display("Test %0d %s: failed with %0d mismatches", testNum, name, testErrs);
            testsFailed++;
        end
        testErrs = 0;
    endtask

endmodule

/* tests/usbRxFrontChk.sv */
`timescale 1ns/1ps

module usbRxFrontChk
    import usbRxFrontPkg::*;
(
    input logic    clk48_i,
    input logic    rst_i,
    input rxBit_t  rxBit_i,
    input rxByte_t rxByte_i,
    input pktEnd_t pktEnd_i,
    input logic    ackEop_i,
    input logic    eopDetected_i
);

    int    failCnt = 0;    // Read by the testbench summary
    byte_t bitHist;        // Last eight decoded bits, newest in the MSB
    logic  endSeen;        // Packet closed and no SYNC since

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            bitHist <= '0;
            endSeen <= 1'b0;
        end else if (pktEnd_i.valid) begin
            bitHist <= '0;
            endSeen <= 1'b1;
        end else begin
            if (rxBit_i.valid) begin
                bitHist <= {rxBit_i.value, bitHist[7:1]};
            end
            if (bitHist == 8'h80) begin
                endSeen <= 1'b0;    // Seven zeros and a one
            end
        end
    end

    byteEndExclusive: assert property (@(posedge clk48_i) disable iff (rst_i)
        !(rxByte_i.valid && pktEnd_i.valid))
    else begin
        failCnt++;
        $error("byte strobe and packet end strobe in the same clock");
    end

    ackOnlyWithEop: assert property (@(posedge clk48_i) disable iff (rst_i)
        ackEop_i |-> eopDetected_i)
    else begin
        failCnt++;
        $error("EOP acknowledge without a pending EOP flag");
    end

    // After a packet end the assembler hunts again, so bytes need a new SYNC
    noByteAfterEnd: assert property (@(posedge clk48_i) disable iff (rst_i)
        rxByte_i.valid |-> !endSeen)
    else begin
        failCnt++;
        $error("byte strobe after packet end without a new SYNC");
    end

endmodule

bind rxByteAssembler usbRxFrontChk chk (
    .clk48_i       (clk48_i),
    .rst_i         (rst_i),
    .rxBit_i       (rxBit_i),
    .rxByte_i      (rxByte_o),
    .pktEnd_i      (pktEnd_o),
    .ackEop_i      (ackEop_o),
    .eopDetected_i (eopDetected_i)
);

/* source/usbRxFrontTop.sv */
`timescale 1ns/1ps

module usbRxFrontTop
    import usbRxFrontPkg::*;
(
    input  logic    clk48_i,
    input  logic    rst_i,

    // Pins
    input  logic    pinP_i,
    input  logic    pinN_i,
    output logic    pinP_o,
    output logic    pinN_o,
    output logic    pinOe_o,

    // Transmit levels
    input  logic    dataOutEn_i,
    input  logic    dataOutP_i,
    input  logic    dataOutN_i,

    // Receive side
    output logic    usbReset_o,
    input  logic    ackUsbRst_i,
    output rxByte_t rxByte_o,
    output pktEnd_t pktEnd_o
);

    lineSample_t line;
    rxBit_t      rxBit;
    logic        eopDetected;
    logic        ackEop;

    usbPinFrontend pinFrontend (
        .clk48_i     (clk48_i),
        .rst_i       (rst_i),
        .pinP_i      (pinP_i),
        .pinN_i      (pinN_i),
        .pinP_o      (pinP_o),
        .pinN_o      (pinN_o),
        .pinOe_o     (pinOe_o),
        .dataOutEn_i (dataOutEn_i),
        .dataOutP_i  (dataOutP_i),
        .dataOutN_i  (dataOutN_i),
        .line_o      (line)
    );

    // Line state path
    eopResetDetect eopDetect (
        .clk48_i            (clk48_i),
        .rst_i              (rst_i),
        .line_i             (line),
        .ackEop_i           (ackEop),
        .ackUsbRst_i        (ackUsbRst_i),
        .eopDetected_o      (eopDetected),
        .usbResetDetected_o (usbReset_o)
    );

    // Bit recovery path
    nrziBitDecoder bitDecoder (
        .clk48_i (clk48_i),
        .rst_i   (rst_i),
        .line_i  (line),
        .rxBit_o (rxBit)
    );

    rxByteAssembler byteAssembler (
        .clk48_i       (clk48_i),
        .rst_i         (rst_i),
        .rxBit_i       (rxBit),
        .eopDetected_i (eopDetected),
        .ackEop_o      (ackEop),
        .rxByte_o      (rxByte_o),
        .pktEnd_o      (pktEnd_o)
    );

endmodule

/* source/rxByteAssembler.sv */
`timescale 1ns/1ps

module rxByteAssembler
    import usbRxFrontPkg::*;
(
    input  logic    clk48_i,
    input  logic    rst_i,
    input  rxBit_t  rxBit_i,
    input  logic    eopDetected_i,
    output logic    ackEop_o,
    output rxByte_t rxByte_o,
    output pktEnd_t pktEnd_o
);

    // Decoded SYNC is seven zeros and a one, shifted in LSB first
    localparam byte_t SYNC_PATTERN = 8'h80;

    asmState_e state;
    byte_t     huntShift;
    byte_t     dataShift;
    byte_t     nextShift;
    logic [2:0] bitCnt;     // Bits of the byte in progress
    logic      errSeen;
    logic      eopNew;

    assign eopNew = eopDetected_i & ~ackEop_o;   // Flag not yet answered

    always_comb begin
        nextShift = state == HUNT ? huntShift : dataShift;
        nextShift = {rxBit_i.value, nextShift[7:1]};
    end

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            state     <= HUNT;
            huntShift <= '0;
            bitCnt    <= '0;
            errSeen   <= 1'b0;
            ackEop_o  <= 1'b0;
            rxByte_o  <= '0;
            pktEnd_o  <= '0;
        end else begin
            rxByte_o.valid <= 1'b0;
            pktEnd_o       <= '0;
            ackEop_o       <= eopNew;

            if (eopNew) begin
                // Close the packet, partial byte or stuff error counts as bad
                if (state == DATA) begin
                    pktEnd_o <= '{valid: 1'b1, error: errSeen | (bitCnt != '0)};
                end
                state     <= HUNT;
                huntShift <= '0;
                bitCnt    <= '0;
                errSeen   <= 1'b0;
            end else if (rxBit_i.valid) begin
                if (state == HUNT) begin
                    huntShift <= nextShift;
                    if (nextShift == SYNC_PATTERN) begin
                        state <= DATA;
                    end
                end else if (rxBit_i.stuffErr) begin
                    errSeen <= 1'b1;       // Bit itself is not trusted
                end else begin
                    bitCnt <= bitCnt + 1'b1;
                    if (bitCnt == 3'd7) begin
                        rxByte_o.valid <= 1'b1;
                        rxByte_o.data  <= nextShift;
                    end
                end
            end
        end
    end

    // Payload shift register needs no reset
    always_ff @(posedge clk48_i) begin
        if (state == DATA && rxBit_i.valid && !rxBit_i.stuffErr) begin
            dataShift <= nextShift;
        end
    end

endmodule

/* source/nrziBitDecoder.sv */
`timescale 1ns/1ps

module nrziBitDecoder
    import usbRxFrontPkg::*;
(
    input  logic        clk48_i,
    input  logic        rst_i,
    input  lineSample_t line_i,
    output rxBit_t      rxBit_o
);

    /*
        NRZI on the line
          level unchanged since the previous bit  -> 1
          level changed since the previous bit    -> 0
        After six ones the sender inserts a zero, which is removed here.
    */

    bitState_e state;
    phase_t    phase;
    onesCnt_t  onesCnt;
    logic      prevDp;      // dp one clock ago, for transition detection
    logic      lastLevel;   // dp at the previous bit sample
    logic      isK;
    logic      isSe0;
    logic      lineEdge;
    logic      bitValue;

    assign isK      = ~line_i.dp & line_i.dn;
    assign isSe0    = ~line_i.dp & ~line_i.dn;
    assign lineEdge = line_i.dp != prevDp;
    assign bitValue = line_i.dp == lastLevel;

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            state     <= IDLE;
            phase     <= '0;
            onesCnt   <= '0;
            prevDp    <= 1'b1;
            lastLevel <= 1'b1;
            rxBit_o   <= '0;
        end else begin
            rxBit_o <= '0;
            prevDp  <= line_i.dp;

            case (state)
                IDLE: begin
                    lastLevel <= 1'b1;    // Previous level is J
                    onesCnt   <= '0;
                    if (isK) begin
                        state <= RUN;
                        phase <= '0;      // First K is the first SYNC transition
                    end
                end

                RUN: begin
                    if (isSe0) begin
                        state <= IDLE;
                    end else if (lineEdge) begin
                        phase <= '0;      // Re-centre on every transition
                    end else begin
                        phase <= phase + 1'b1;

                        if (phase == SAMPLE_PHASE) begin
                            lastLevel <= line_i.dp;
                            if (bitValue) begin
                                if (onesCnt == onesCnt_t'(STUFF_LIMIT)) begin
                                    // Seventh one, the stuffed zero is missing
                                    rxBit_o <= '{valid: 1'b1, value: 1'b1, stuffErr: 1'b1};
                                    onesCnt <= '0;
                                end else begin
                                    rxBit_o <= '{valid: 1'b1, value: 1'b1, stuffErr: 1'b0};
                                    onesCnt <= onesCnt + 1'b1;
                                end
                            end else begin
                                if (onesCnt != onesCnt_t'(STUFF_LIMIT)) begin
                                    rxBit_o <= '{valid: 1'b1, value: 1'b0, stuffErr: 1'b0};
                                end
                                onesCnt <= '0;    // Stuffed zero dropped above
                            end
                        end
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* source/eopResetDetect.sv */
`timescale 1ns/1ps

module eopResetDetect
    import usbRxFrontPkg::*;
(
    input  logic        clk48_i,
    input  logic        rst_i,
    input  lineSample_t line_i,
    input  logic        ackEop_i,
    input  logic        ackUsbRst_i,
    output logic        eopDetected_o,
    output logic        usbResetDetected_o
);

    se0Cnt_t se0Cnt;
    logic    isSe0;
    logic    isJ;
    logic    eopSeen;
    logic    resetSeen;

    assign isSe0 = ~line_i.dp & ~line_i.dn;
    assign isJ   = line_i.dp & ~line_i.dn;

    // J after a long enough SE0 closes a packet, unless the SE0 was already a reset
    assign eopSeen = isJ && (se0Cnt >= se0Cnt_t'(EOP_MIN_CYCLES))
                         && (se0Cnt < se0Cnt_t'(RESET_CYCLES));

    // Count reaches RESET_CYCLES on this clock
    assign resetSeen = isSe0 && (se0Cnt == se0Cnt_t'(RESET_CYCLES - 1));

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            se0Cnt <= '0;
        end else if (isSe0) begin
            if (se0Cnt != '1) begin
                se0Cnt <= se0Cnt + 1'b1;   // Saturates at full scale
            end
        end else begin
            se0Cnt <= '0;
        end
    end

    // Held flags, each cleared by its own acknowledge
    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            eopDetected_o <= 1'b0;
        end else begin
            if (ackEop_i) begin
                eopDetected_o <= 1'b0;
            end
            if (eopSeen) begin
                eopDetected_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            usbResetDetected_o <= 1'b0;
        end else begin
            if (ackUsbRst_i) begin
                usbResetDetected_o <= 1'b0;
            end
            if (resetSeen) begin
                usbResetDetected_o <= 1'b1;
            end
        end
    end

endmodule

/* source/usbPinFrontend.sv */
`timescale 1ns/1ps

module usbPinFrontend
    import usbRxFrontPkg::*;
(
    input  logic        clk48_i,
    input  logic        rst_i,

    // Pins
    input  logic        pinP_i,
    input  logic        pinN_i,
    output logic        pinP_o,
    output logic        pinN_o,
    output logic        pinOe_o,

    // Transmit levels from the caller
    input  logic        dataOutEn_i,
    input  logic        dataOutP_i,
    input  logic        dataOutN_i,

    // Synchronized and blanked receive line
    output lineSample_t line_o
);

    lineSample_t                   pinSample;
    lineSample_t [SYNC_STAGES-1:0] syncStage;
    logic [BLANK_TAIL-1:0]         oeHist;
    logic                          blankRx;

    // Pins idle at J while the output is disabled
    assign pinP_o  = dataOutEn_i ? dataOutP_i : 1'b1;
    assign pinN_o  = dataOutEn_i ? dataOutN_i : 1'b0;
    assign pinOe_o = dataOutEn_i;

    assign pinSample.dp = pinP_i;
    assign pinSample.dn = pinN_i;

    // Own transmission and its echo through the sync stages are never heard
    assign blankRx = dataOutEn_i | (|oeHist);

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            oeHist <= '0;
        end else begin
            oeHist <= {oeHist[BLANK_TAIL-2:0], dataOutEn_i};
        end
    end

    // Metastability guard on both line inputs
    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            syncStage <= {SYNC_STAGES{LINE_J}};
        end else begin
            syncStage <= {syncStage[SYNC_STAGES-2:0], pinSample};
        end
    end

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            line_o <= LINE_J;
        end else if (blankRx) begin
            line_o <= LINE_J;   // Forced idle
        end else begin
            line_o <= syncStage[SYNC_STAGES-1];
        end
    end

endmodule

/* source/usbRxFrontPkg.sv */
package usbRxFrontPkg;

    // Line timing at 48 MHz, four samples per full-speed bit
    localparam int SAMPLES_PER_BIT = 4;
    localparam int SYNC_STAGES     = 2;     // Input double flop depth
    localparam int BLANK_TAIL      = 2;     // Clocks of blanking after output enable drops
    localparam int EOP_MIN_CYCLES  = 6;     // SE0 length that qualifies as EOP
    localparam int RESET_CYCLES    = 120;   // SE0 length of a bus reset, 2.5 us
    localparam int STUFF_LIMIT     = 6;     // Ones before a stuffed zero

    typedef logic [7:0] byte_t;
    typedef logic [1:0] phase_t;       // Sample position inside one bit
    typedef logic [7:0] se0Cnt_t;      // Saturating SE0 duration
    typedef logic [2:0] onesCnt_t;     // Run of consecutive ones

    // Mid-bit sample point, counted from the transition that re-centres the phase
    localparam phase_t SAMPLE_PHASE = phase_t'(SAMPLES_PER_BIT / 2 - 1);

    typedef struct packed {
        logic dp;
        logic dn;
    } lineSample_t;

    // Idle state of a full-speed line
    localparam lineSample_t LINE_J = '{dp: 1'b1, dn: 1'b0};

    typedef struct packed {
        logic valid;
        logic value;
        logic stuffErr;    // Seventh one seen without a stuffed zero
    } rxBit_t;

    typedef struct packed {
        logic  valid;
        byte_t data;
    } rxByte_t;

    typedef struct packed {
        logic valid;
        logic error;
    } pktEnd_t;

    typedef enum logic {IDLE, RUN} bitState_e;
    typedef enum logic {HUNT, DATA} asmState_e;

endpackage
